// File: src/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    // Address of this leaf in the tree.
    localparam logic [LEAF_BITS-1:0] LEAF_ID = 5'd5;

    // The dest_port field of an incoming packet tells its kind.
    typedef enum logic [PORT_BITS-1:0] {
        CONFIG_PORT = 4'd0,
        DATA_PORT   = 4'd1
    } packet_kind_t;

    typedef struct packed {
        logic                    valid;
        logic [LEAF_BITS-1:0]    dest_leaf;
        logic [PORT_BITS-1:0]    dest_port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } leaf_packet_t;

    // Destination of one output port, as written by a configuration packet.
    typedef struct packed {
        logic [LEAF_BITS-1:0] dest_leaf;
        logic [PORT_BITS-1:0] dest_port;
    } route_entry_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESET_USER,
        ST_RUN
    } start_state_t;

endpackage

`default_nettype wire

// File: src/leaf_rx.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_rx import leaf_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  leaf_packet_t            din_leaf_bft2interface,
    input  logic                    ack_from_user,
    output logic [PAYLOAD_BITS-1:0] word_to_user,
    output logic                    vld_to_user,
    output logic                    cfg_we,
    output logic [2:0]              cfg_index,
    output route_entry_t            cfg_entry
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    for_us;
    logic                    is_cfg;
    logic                    is_data;
    logic                    fifo_full;
    logic                    push;
    logic                    pop;

    assign for_us = din_leaf_bft2interface.valid &&
                    (din_leaf_bft2interface.dest_leaf == LEAF_ID);

    // Only the low three address bits can name a port; wider addresses are dropped here.
    assign is_cfg = for_us && (din_leaf_bft2interface.dest_port == CONFIG_PORT) &&
                    (din_leaf_bft2interface.addr[ADDR_BITS-1:3] == '0);
    assign is_data = for_us && (din_leaf_bft2interface.dest_port == DATA_PORT);

    assign fifo_full = (count == CNT_W'(FIFO_DEPTH));
    assign push      = is_data && !fifo_full;
    assign pop       = ack_from_user && vld_to_user;

    assign vld_to_user  = (count != '0);
    assign word_to_user = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din_leaf_bft2interface.payload;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= is_cfg;
        end
    end

    // The route entry sits in the low payload bits, leaf above port.
    always_ff @(posedge clk) begin
        if (is_cfg) begin
            cfg_index <= din_leaf_bft2interface.addr[2:0];
            cfg_entry <= route_entry_t'(din_leaf_bft2interface.payload[$bits(route_entry_t)-1:0]);
        end
    end

endmodule

`default_nettype wire

// File: src/leaf_route_table.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_route_table import leaf_pkg::*; #(
    parameter int NUM_OUT_PORTS = 5
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cfg_we,
    input  logic [2:0]                       cfg_index,
    input  route_entry_t                     cfg_entry,
    output route_entry_t [NUM_OUT_PORTS-1:0] routes
);

    logic index_ok;

    assign index_ok = (int'(cfg_index) < NUM_OUT_PORTS);

    // Every port points at leaf 0, port 0 until it is configured.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            routes <= '0;
        end else if (cfg_we && index_ok) begin
            routes[cfg_index] <= cfg_entry;
        end
    end

endmodule

`default_nettype wire

// File: src/leaf_tx.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_tx import leaf_pkg::*; #(
    parameter int NUM_OUT_PORTS = 5,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [PAYLOAD_BITS-1:0]          word_from_user,
    input  logic [NUM_OUT_PORTS-1:0]         vld_from_user,
    input  route_entry_t [NUM_OUT_PORTS-1:0] routes,
    output logic [NUM_OUT_PORTS-1:0]         ack_to_user,
    output leaf_packet_t                     dout
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int IDX_W = (NUM_OUT_PORTS > 1) ? $clog2(NUM_OUT_PORTS) : 1;

    logic [NUM_OUT_PORTS-1:0]                   nonempty;
    logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] head;
    logic                                       grant_any;
    logic [IDX_W-1:0]                           grant_idx;
    logic [IDX_W-1:0]                           rr_ptr;

    logic                    out_valid;
    route_entry_t            out_route;
    logic [ADDR_BITS-1:0]    out_addr;
    logic [PAYLOAD_BITS-1:0] out_payload;

    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : g_port
        logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
        logic [PTR_W-1:0]        wr_ptr;
        logic [PTR_W-1:0]        rd_ptr;
        logic [CNT_W-1:0]        count;
        logic                    push;
        logic                    pop;

        // The kernel holds its word until this ack, so a full FIFO stalls it.
        assign push           = vld_from_user[i] && (count != CNT_W'(FIFO_DEPTH));
        assign pop            = grant_any && (grant_idx == IDX_W'(i));
        assign ack_to_user[i] = push;
        assign nonempty[i]    = (count != '0);
        assign head[i]        = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= word_from_user;
            end
        end
    end

    // Search starts at rr_ptr and wraps, so the first non-empty port from there wins.
    always_comb begin
        int cand;
        grant_any = 1'b0;
        grant_idx = '0;
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            cand = int'(rr_ptr) + k;
            if (cand >= NUM_OUT_PORTS) begin
                cand = cand - NUM_OUT_PORTS;
            end
            if (!grant_any && nonempty[cand]) begin
                grant_any = 1'b1;
                grant_idx = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (grant_any) begin
                rr_ptr <= (grant_idx == IDX_W'(NUM_OUT_PORTS - 1)) ? '0 : grant_idx + 1'b1;
            end
            out_valid <= grant_any;
        end
    end

    // Ports are numbered from 1 on the network side.
    always_ff @(posedge clk) begin
        if (grant_any) begin
            out_route   <= routes[grant_idx];
            out_addr    <= ADDR_BITS'(grant_idx) + ADDR_BITS'(1);
            out_payload <= head[grant_idx];
        end
    end

    assign dout = '{
        valid:     out_valid,
        dest_leaf: out_route.dest_leaf,
        dest_port: out_route.dest_port,
        addr:      out_addr,
        payload:   out_payload
    };

endmodule

`default_nettype wire

// File: src/leaf_interface.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_interface import leaf_pkg::*; #(
    parameter int NUM_OUT_PORTS = 5,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  leaf_packet_t             din_leaf_bft2interface,
    input  logic                     ap_start,
    input  logic                     ack_from_user,
    input  logic [PAYLOAD_BITS-1:0]  word_from_user,
    input  logic [NUM_OUT_PORTS-1:0] vld_from_user,
    output leaf_packet_t             dout_leaf_interface2bft,
    output logic                     user_rst_n,
    output logic [PAYLOAD_BITS-1:0]  word_to_user,
    output logic                     vld_to_user,
    output logic [NUM_OUT_PORTS-1:0] ack_to_user
);

    localparam int USER_RESET_CYCLES = 4;

    logic                             cfg_we;
    logic [2:0]                       cfg_index;
    route_entry_t                     cfg_entry;
    route_entry_t [NUM_OUT_PORTS-1:0] routes;

    start_state_t state_q;
    logic [1:0]   hold_cnt;

    leaf_rx #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rx (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .ack_from_user          (ack_from_user),
        .word_to_user           (word_to_user),
        .vld_to_user            (vld_to_user),
        .cfg_we                 (cfg_we),
        .cfg_index              (cfg_index),
        .cfg_entry              (cfg_entry)
    );

    leaf_route_table #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) u_route_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_index (cfg_index),
        .cfg_entry (cfg_entry),
        .routes    (routes)
    );

    leaf_tx #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_tx (
        .clk            (clk),
        .rst_n          (rst_n),
        .word_from_user (word_from_user),
        .vld_from_user  (vld_from_user),
        .routes         (routes),
        .ack_to_user    (ack_to_user),
        .dout           (dout_leaf_interface2bft)
    );

    // The kernel stays in reset until ap_start, then gets a few clean reset cycles.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            hold_cnt <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    hold_cnt <= '0;
                    if (ap_start) begin
                        state_q <= ST_RESET_USER;
                    end
                end
                ST_RESET_USER: begin
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_cnt == 2'(USER_RESET_CYCLES - 1)) begin
                        state_q <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    state_q <= ST_RUN;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign user_rst_n = (state_q == ST_RUN);

endmodule

`default_nettype wire

// File: src/user_kernel.sv
`timescale 1ns/1ps
`default_nettype none

module user_kernel import leaf_pkg::*; #(
    parameter int NUM_OUT_PORTS = 5
) (
    input  logic                     clk,
    input  logic                     user_rst_n,
    input  logic [PAYLOAD_BITS-1:0]  word_to_user,
    input  logic                     vld_to_user,
    input  logic [NUM_OUT_PORTS-1:0] ack_to_user,
    output logic                     ack_from_user,
    output logic [PAYLOAD_BITS-1:0]  word_from_user,
    output logic [NUM_OUT_PORTS-1:0] vld_from_user
);

    logic                     live_q;
    logic                     pending;
    logic [NUM_OUT_PORTS-1:0] target;
    logic [NUM_OUT_PORTS-1:0] vld_q;
    logic [PAYLOAD_BITS-1:0]  word_q;

    assign pending = |vld_q;

    // Low three bits pick the port; anything out of range goes to the last port.
    always_comb begin
        target = '0;
        if (int'(word_to_user[2:0]) < NUM_OUT_PORTS) begin
            target[word_to_user[2:0]] = 1'b1;
        end else begin
            target[NUM_OUT_PORTS-1] = 1'b1;
        end
    end

    assign ack_from_user = vld_to_user && live_q && !pending;

    always_ff @(posedge clk) begin
        if (!user_rst_n) begin
            live_q <= 1'b0;
            vld_q  <= '0;
        end else begin
            live_q <= 1'b1;
            if (ack_from_user) begin
                vld_q <= target;
            end else if (|(vld_q & ack_to_user)) begin
                vld_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ack_from_user) begin
            word_q <= word_to_user;
        end
    end

    assign word_from_user = word_q;
    assign vld_from_user  = vld_q;

endmodule

`default_nettype wire

// File: src/leaf_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_wrapper import leaf_pkg::*; #(
    parameter int NUM_OUT_PORTS = 5,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  leaf_packet_t din_leaf_bft2interface,
    input  logic         resend,
    input  logic         ap_start,
    output leaf_packet_t dout_leaf_interface2bft
);

    leaf_packet_t             dout_tmp;
    logic                     user_rst_n;
    logic [PAYLOAD_BITS-1:0]  word_to_user;
    logic                     vld_to_user;
    logic                     ack_from_user;
    logic [PAYLOAD_BITS-1:0]  word_from_user;
    logic [NUM_OUT_PORTS-1:0] vld_from_user;
    logic [NUM_OUT_PORTS-1:0] ack_to_user;

    // Packets leaving during a resend window are lost.
    assign dout_leaf_interface2bft = resend ? '0 : dout_tmp;

    leaf_interface #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_leaf_interface (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .ap_start                (ap_start),
        .ack_from_user           (ack_from_user),
        .word_from_user          (word_from_user),
        .vld_from_user           (vld_from_user),
        .dout_leaf_interface2bft (dout_tmp),
        .user_rst_n              (user_rst_n),
        .word_to_user            (word_to_user),
        .vld_to_user             (vld_to_user),
        .ack_to_user             (ack_to_user)
    );

    user_kernel #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) u_user_kernel (
        .clk            (clk),
        .user_rst_n     (user_rst_n),
        .word_to_user   (word_to_user),
        .vld_to_user    (vld_to_user),
        .ack_to_user    (ack_to_user),
        .ack_from_user  (ack_from_user),
        .word_from_user (word_from_user),
        .vld_from_user  (vld_from_user)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a falling edge like every other input.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/leaf_wrapper_properties.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_wrapper_properties import leaf_pkg::*; #(
    parameter int NUM_OUT_PORTS = 5,
    parameter int FIFO_DEPTH    = 4
) (
    input logic         clk,
    input logic         rst_n,
    input leaf_packet_t din_leaf_bft2interface,
    input logic         resend,
    input logic         ap_start,
    input leaf_packet_t dout_leaf_interface2bft
);

    localparam int MAX_FORBIDDEN = 16;

    leaf_packet_t                     din;
    leaf_packet_t                     dout;
    route_entry_t [NUM_OUT_PORTS-1:0] shadow_q;
    route_entry_t [NUM_OUT_PORTS-1:0] shadow_d1;
    route_entry_t [NUM_OUT_PORTS-1:0] shadow_d2;
    logic [PAYLOAD_BITS-1:0]          forbidden [MAX_FORBIDDEN];
    int                               forbid_cnt;
    int                               held_cnt;
    logic                             started;
    logic                             for_us;
    logic                             forbid_now;
    logic                             forbidden_hit;
    logic                             route_ok;
    logic [ADDR_BITS-1:0]             exp_addr;
    int                               fail_count = 0;

    assign din    = din_leaf_bft2interface;
    assign dout   = dout_leaf_interface2bft;
    assign for_us = din.valid && (din.dest_leaf == LEAF_ID);

    // Before start nothing pops the receive FIFO, so words past its depth are lost.
    assign forbid_now = (din.valid && (din.dest_leaf != LEAF_ID)) ||
                        (for_us && (din.dest_port == DATA_PORT) && !started &&
                         (held_cnt >= FIFO_DEPTH));

    // A write reaches the transmit stage two cycles after the shadow sees it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_q   <= '0;
            shadow_d1  <= '0;
            shadow_d2  <= '0;
            forbid_cnt <= 0;
            held_cnt   <= 0;
            started    <= 1'b0;
        end else begin
            shadow_d1 <= shadow_q;
            shadow_d2 <= shadow_d1;
            if (for_us && (din.dest_port == CONFIG_PORT) &&
                (din.addr < ADDR_BITS'(NUM_OUT_PORTS))) begin
                shadow_q[din.addr[2:0]] <= route_entry_t'(din.payload[8:0]);
            end
            if (ap_start) begin
                started <= 1'b1;
            end
            if (for_us && (din.dest_port == DATA_PORT) && !started) begin
                held_cnt <= held_cnt + 1;
            end
            if (forbid_now && (forbid_cnt < MAX_FORBIDDEN)) begin
                forbidden[forbid_cnt] <= din.payload;
                forbid_cnt            <= forbid_cnt + 1;
            end
        end
    end

    always_comb begin
        forbidden_hit = 1'b0;
        for (int i = 0; i < MAX_FORBIDDEN; i++) begin
            if ((i < forbid_cnt) && (forbidden[i] == dout.payload)) begin
                forbidden_hit = 1'b1;
            end
        end
    end

    always_comb begin
        if (int'(dout.payload[2:0]) < NUM_OUT_PORTS) begin
            exp_addr = ADDR_BITS'(dout.payload[2:0]) + ADDR_BITS'(1);
        end else begin
            exp_addr = ADDR_BITS'(NUM_OUT_PORTS);
        end
        route_ok = 1'b0;
        if ((dout.addr >= 1) && (dout.addr <= ADDR_BITS'(NUM_OUT_PORTS))) begin
            route_ok = (shadow_d2[dout.addr - 1] == {dout.dest_leaf, dout.dest_port});
        end
    end

    a_resend_zero: assert property (@(posedge clk) resend |-> (dout == '0))
        else begin
            fail_count++;
            $error("Mismatch at %0t: output packet is not zero while resend is high", $time);
        end

    a_quiet_before_start: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !dout.valid)
        else begin
            fail_count++;
            $error("Mismatch at %0t: valid packet out before ap_start", $time);
        end

    a_route: assert property (@(posedge clk) disable iff (!rst_n) dout.valid |-> route_ok)
        else begin
            fail_count++;
            $error("Mismatch at %0t: destination %0d/%0d differs from route of port %0d",
                   $time, dout.dest_leaf, dout.dest_port, dout.addr);
        end

    a_port: assert property (@(posedge clk) disable iff (!rst_n)
        dout.valid |-> (dout.addr == exp_addr))
        else begin
            fail_count++;
            $error("Mismatch at %0t: payload %h left on port %0d, expected %0d",
                   $time, dout.payload, dout.addr, exp_addr);
        end

    a_no_lost_word: assert property (@(posedge clk) disable iff (!rst_n)
        dout.valid |-> !forbidden_hit)
        else begin
            fail_count++;
            $error("Mismatch at %0t: payload %h should never have left this leaf",
                   $time, dout.payload);
        end

    for (genvar p = 1; p <= NUM_OUT_PORTS; p++) begin : g_cover
        c_port: cover property (@(posedge clk) dout.valid && (dout.addr == ADDR_BITS'(p)));
    end

endmodule

`default_nettype wire

// File: tb/tb_leaf_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_leaf_wrapper import leaf_pkg::*; ();

    localparam int                   TIMEOUT_CYCLES = 2000;
    localparam int                   NUM_PORTS      = 5;
    localparam int                   RX_DEPTH       = 4;
    localparam logic [LEAF_BITS-1:0] OTHER_LEAF     = 5'd3;

    logic                    clk;
    logic                    rst_n;
    leaf_packet_t            din;
    logic                    resend;
    logic                    ap_start;
    leaf_packet_t            dout;
    logic [15:0]             lfsr;
    logic [7:0]              seq;
    logic [PAYLOAD_BITS-1:0] last_payload;
    logic [PAYLOAD_BITS-1:0] held_words [RX_DEPTH];
    logic [RX_DEPTH-1:0]     held_seen;
    logic [NUM_PORTS-1:0]    ports_seen;
    int                      cycle_count;
    int                      delivery_errors = 0;
    int                      timeouts = 0;

    tb_clock #(.PERIOD_NS(10), .RESET_CYCLES(16)) u_clock (.clk(clk), .rst_n(rst_n));

    leaf_wrapper #(
        .NUM_OUT_PORTS (NUM_PORTS),
        .FIFO_DEPTH    (RX_DEPTH)
    ) DUT (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .resend                  (resend),
        .ap_start                (ap_start),
        .dout_leaf_interface2bft (dout)
    );

    bind leaf_wrapper leaf_wrapper_properties #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_props (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .resend                  (resend),
        .ap_start                (ap_start),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic send_packet(input logic [LEAF_BITS-1:0] leaf, input logic [PORT_BITS-1:0] port,
                               input logic [ADDR_BITS-1:0] addr,
                               input logic [PAYLOAD_BITS-1:0] payload);
        int gap;
        @(negedge clk);
        din = '{valid: 1'b1, dest_leaf: leaf, dest_port: port, addr: addr, payload: payload};
        @(negedge clk);
        din = '0;
        gap = 1 + int'(take_bits(2));
        repeat (gap) @(negedge clk);
    endtask

    // The sequence number in the low byte makes every payload unique and cycles the ports.
    task automatic send_data(input logic [LEAF_BITS-1:0] leaf);
        logic [23:0] noise;
        noise        = 24'(take_bits(24));
        last_payload = {noise, seq};
        send_packet(leaf, DATA_PORT, '0, last_payload);
        seq++;
    endtask

    task automatic send_config(input int index, input logic [LEAF_BITS-1:0] leaf,
                               input logic [PORT_BITS-1:0] port);
        route_entry_t entry;
        entry = '{dest_leaf: leaf, dest_port: port};
        send_packet(LEAF_ID, CONFIG_PORT, ADDR_BITS'(index), PAYLOAD_BITS'(entry));
    endtask

    task automatic wait_for_drain();
        int quiet;
        quiet = 0;
        while (quiet < 20) begin
            @(negedge clk);
            if (dout.valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    // A port or a held word counts as delivered once a valid packet carries it.
    always @(posedge clk) begin
        if (!rst_n) begin
            ports_seen <= '0;
            held_seen  <= '0;
        end else if (dout.valid) begin
            if ((dout.addr >= 1) && (dout.addr <= ADDR_BITS'(NUM_PORTS))) begin
                ports_seen[dout.addr - 1] <= 1'b1;
            end
            for (int k = 0; k < RX_DEPTH; k++) begin
                if (dout.payload == held_words[k]) begin
                    held_seen[k] <= 1'b1;
                end
            end
        end
    end

    task automatic report_and_finish();
        assert (ports_seen == '1) else begin
            delivery_errors++;
            $display("Not every output port carried a packet (seen %b)", ports_seen);
        end
        assert (held_seen == '1) else begin
            delivery_errors++;
            $display("Words held before ap_start did not all come out (seen %b)", held_seen);
        end
        $display("Assertion failures: %0d, delivery failures: %0d, timeouts: %0d",
                 DUT.u_props.fail_count, delivery_errors, timeouts);
        if ((DUT.u_props.fail_count == 0) && (delivery_errors == 0) && (timeouts == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        timeouts = 1;
        report_and_finish();
    end

    initial begin
        din      = '0;
        resend   = 1'b0;
        ap_start = 1'b0;
        lfsr     = 16'd9066;
        seq      = '0;
        @(posedge rst_n);
        repeat (4) @(negedge clk);
        // Six words for a four-deep receive FIFO while the kernel is held in reset.
        for (int i = 0; i < 6; i++) begin
            send_data(LEAF_ID);
            if (i < RX_DEPTH) begin
                held_words[i] = last_payload;
            end
        end
        repeat (10) @(negedge clk);
        ap_start = 1'b1;
        @(negedge clk);
        ap_start = 1'b0;
        for (int p = 0; p < 5; p++) begin
            send_config(p, 5'(10 + p), 4'(p + 2));
        end
        for (int i = 0; i < 40; i++) begin
            send_data((i % 8 == 7) ? OTHER_LEAF : LEAF_ID);
        end
        @(negedge clk);
        resend = 1'b1;
        repeat (3) send_data(LEAF_ID);
        repeat (4) @(negedge clk);
        resend = 1'b0;
        send_config(1, 5'd20, 4'd9);
        send_config(3, 5'd21, 4'd11);
        for (int i = 0; i < 20; i++) begin
            send_data((i % 8 == 3) ? OTHER_LEAF : LEAF_ID);
        end
        wait_for_drain();
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: all.f
src/leaf_pkg.sv
src/leaf_rx.sv
src/leaf_route_table.sv
src/leaf_tx.sv
src/leaf_interface.sv
src/user_kernel.sv
src/leaf_wrapper.sv
tb/tb_clock.sv
tb/leaf_wrapper_properties.sv
tb/tb_leaf_wrapper.sv
